/* hdl/cache_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// cache widths, request op, core/line request structs
// and the two-view line union
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package cache_pkg;

  // core side
  localparam int ADDR_W = 64;  // byte address
  localparam int WORD_W = 64;  // core data word

  // line side
  localparam int LINE_W = 512;            // one 64-byte line
  localparam int LINE_BYTES = LINE_W / 8;
  localparam int LINE_WORDS = LINE_W / WORD_W;
  localparam int OFFS_W = $clog2(LINE_BYTES);  // 6 offset bits

  typedef enum logic {
    REQ_READ  = 1'b0,
    REQ_WRITE = 1'b1
  } req_op_e;

  // single-word request from the exerciser
  typedef struct packed {
    logic [ADDR_W-1:0] addr;   // byte address
    logic [WORD_W-1:0] wdata;  // lane 0 sits at addr
    logic [2:0]        bytes;  // byte count minus one
    req_op_e           op;
  } core_req_t;

  // one line transfer on the memory side
  typedef struct packed {
    req_op_e           op;
    logic [ADDR_W-1:0] addr;   // low OFFS_W bits zero
    logic [LINE_W-1:0] wdata;  // write-back payload
  } line_req_t;

  // same line storage, read as words or merged as bytes
  typedef union packed {
    logic [LINE_WORDS-1:0][WORD_W-1:0] words;
    logic [LINE_BYTES-1:0][7:0]        bytes;
  } cache_line_u;

endpackage

`default_nettype wire

/* hdl/cache_array.sv */
// ~~~~~~~~~~~~~~~~~~~~
// direct-mapped tag, valid/dirty and line storage
// byte-lane write merge and word select
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module cache_array #(
  parameter int SETS = 4,
  localparam int IDX_W = $clog2(SETS),
  localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::OFFS_W - IDX_W
) (
  input  wire                            clk,
  input  wire                            rst,
  input  wire [IDX_W-1:0]                i_index,
  input  wire [TAG_W-1:0]                i_tag,
  input  wire                            i_fill,
  input  wire cache_pkg::cache_line_u    i_fill_line,
  input  wire                            i_write,
  input  wire cache_pkg::core_req_t      i_req,
  input  wire                            i_clean,
  output logic                           o_hit,
  output logic                           o_dirty,
  output logic [TAG_W-1:0]               o_victim_tag,
  output cache_pkg::cache_line_u         o_line,
  output logic [cache_pkg::WORD_W-1:0]   o_word
);
  import cache_pkg::*;

  logic             valid_q [SETS];
  logic             dirty_q [SETS];
  logic [TAG_W-1:0] tag_q   [SETS];
  cache_line_u      data_q  [SETS];

  cache_line_u       merged;  // stored line with request lanes dropped in
  logic [OFFS_W-1:0] offs;
  int                lane;

  assign offs = i_req.addr[OFFS_W-1:0];

  // lookup, combinational from the held request
  assign o_line       = data_q[i_index];
  assign o_victim_tag = tag_q[i_index];
  assign o_hit        = valid_q[i_index] && (tag_q[i_index] == i_tag);
  assign o_dirty      = valid_q[i_index] && dirty_q[i_index];
  assign o_word       = o_line.words[i_req.addr[OFFS_W-1:3]];

  // lanes offs .. offs+bytes take request data, the rest keep the line
  always_comb begin
    merged = o_line;
    lane   = 0;
    for (int b = 0; b < LINE_BYTES; b++) begin
      lane = b - int'(offs);
      if (lane >= 0 && lane <= int'(i_req.bytes)) begin
        merged.bytes[b] = i_req.wdata[8*lane +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < SETS; s++) begin
        valid_q[s] <= 1'b0;
        dirty_q[s] <= 1'b0;
      end
    end else if (i_fill) begin
      valid_q[i_index] <= 1'b1;
      dirty_q[i_index] <= 1'b0;  // refilled line is clean
    end else if (i_write) begin
      dirty_q[i_index] <= 1'b1;
    end else if (i_clean) begin
      dirty_q[i_index] <= 1'b0;  // victim went out to memory
    end
  end

  // tag and line payload
  always_ff @(posedge clk) begin
    if (i_fill) begin
      tag_q[i_index]  <= i_tag;
      data_q[i_index] <= i_fill_line;
    end else if (i_write) begin
      data_q[i_index] <= merged;
    end
  end

endmodule

`default_nettype wire

/* hdl/cache_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~
// cache FSM: lookup, write-back, refill, acknowledge
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module cache_ctrl #(
  parameter int SETS = 4,
  localparam int IDX_W = $clog2(SETS),
  localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::OFFS_W - IDX_W
) (
  input  wire                            clk,
  input  wire                            rst,
  // core port
  input  wire cache_pkg::core_req_t      i_req,
  input  wire                            i_req_valid,
  output logic                           o_ack,
  output logic [cache_pkg::WORD_W-1:0]   o_rdata,
  // line port
  output cache_pkg::line_req_t           o_mem,
  output logic                           o_mem_valid,
  input  wire                            i_mem_ready,
  input  wire [cache_pkg::LINE_W-1:0]    i_mem_rdata,
  // array port
  output logic [IDX_W-1:0]               o_index,
  output logic [TAG_W-1:0]               o_tag,
  output logic                           o_fill,
  output cache_pkg::cache_line_u         o_fill_line,
  output logic                           o_write,
  output cache_pkg::core_req_t           o_arr_req,
  output logic                           o_clean,
  input  wire                            i_hit,
  input  wire                            i_dirty,
  input  wire [TAG_W-1:0]                i_victim_tag,
  input  wire cache_pkg::cache_line_u    i_line,
  input  wire [cache_pkg::WORD_W-1:0]    i_word
);
  import cache_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_WBACK,
    ST_REFILL
  } state_e;

  state_e    state_q;
  core_req_t req_q;       // request held for the whole miss sequence
  line_req_t refill_req;
  line_req_t wback_req;
  logic      accept;

  // ack still high means the exerciser has not dropped req yet
  assign accept = (state_q == ST_IDLE) && i_req_valid && !o_ack;

  assign o_arr_req   = req_q;
  assign o_index     = req_q.addr[OFFS_W +: IDX_W];
  assign o_tag       = req_q.addr[ADDR_W-1 -: TAG_W];
  assign o_fill_line = i_mem_rdata;

  // array strobes
  assign o_write = (state_q == ST_LOOKUP) && i_hit && (req_q.op == REQ_WRITE);
  assign o_fill  = (state_q == ST_REFILL) && i_mem_ready;
  assign o_clean = (state_q == ST_WBACK) && i_mem_ready;

  always_comb begin
    refill_req.op    = REQ_READ;
    refill_req.addr  = {o_tag, o_index, {OFFS_W{1'b0}}};
    refill_req.wdata = '0;
    wback_req.op     = REQ_WRITE;
    wback_req.addr   = {i_victim_tag, o_index, {OFFS_W{1'b0}}};  // victim's own address
    wback_req.wdata  = i_line;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= ST_IDLE;
      o_ack       <= 1'b0;
      o_mem_valid <= 1'b0;
    end else begin
      o_ack <= 1'b0;  // single-cycle pulse
      case (state_q)
        ST_IDLE: begin
          if (accept) state_q <= ST_LOOKUP;
        end
        ST_LOOKUP: begin
          if (i_hit) begin
            o_ack   <= 1'b1;
            state_q <= ST_IDLE;
          end else begin
            o_mem_valid <= 1'b1;
            state_q     <= i_dirty ? ST_WBACK : ST_REFILL;
          end
        end
        ST_WBACK: begin
          if (i_mem_ready) state_q <= ST_REFILL;  // valid stays up for the refill
        end
        ST_REFILL: begin
          if (i_mem_ready) begin
            o_mem_valid <= 1'b0;
            state_q     <= ST_LOOKUP;  // retry, hits this time
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (accept) req_q <= i_req;
    if (state_q == ST_LOOKUP) begin
      if (i_hit) o_rdata <= i_word;
      else if (i_dirty) o_mem <= wback_req;
      else o_mem <= refill_req;
    end
    if (state_q == ST_WBACK && i_mem_ready) o_mem <= refill_req;
  end

endmodule

`default_nettype wire

/* hdl/cache_exerciser.sv */
// ~~~~~~~~~~~~~~~~~~~~
// self-test traffic: LFSR writes, readback compare
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module cache_exerciser #(
  parameter int GAP_CYCLES = 5
) (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            i_start,
  input  wire [63:0]                     i_seed,
  input  wire [63:0]                     i_base,      // 8-byte aligned
  input  wire [15:0]                     i_words,
  input  wire [2:0]                      i_wr_bytes,
  output cache_pkg::core_req_t           o_req,
  output logic                           o_req_valid,
  input  wire                            i_ack,
  input  wire [cache_pkg::WORD_W-1:0]    i_rdata,
  output logic                           o_busy,
  output logic                           o_done,
  output logic [15:0]                    o_err_cnt,
  output logic [cache_pkg::WORD_W-1:0]   o_last_rdata
);
  import cache_pkg::*;

  localparam int CNT_W = (GAP_CYCLES > 0) ? $clog2(GAP_CYCLES + 1) : 1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_GAP,
    ST_REQ,
    ST_DONE
  } state_e;

  state_e            state_q;
  logic [CNT_W-1:0]  gap_q;       // pause counter
  logic [63:0]       lfsr_q;
  logic [63:0]       lfsr_next;
  logic [15:0]       words_q;     // words still to do
  logic [2:0]        wr_bytes_q;
  logic [WORD_W-1:0] lane_mask;
  logic              mismatch;
  logic              start_ok;
  logic              last_word;

  assign start_ok  = (state_q == ST_IDLE || state_q == ST_DONE) && i_start;
  assign last_word = (words_q == 16'd1);
  assign lfsr_next = {lfsr_q[62:0], lfsr_q[63] ^ lfsr_q[62] ^ lfsr_q[60] ^ lfsr_q[59]};

  assign o_busy = (state_q == ST_GAP) || (state_q == ST_REQ);
  assign o_done = (state_q == ST_DONE);

  // only the written lanes count, wdata still holds the written value
  always_comb begin
    lane_mask = '0;
    for (int k = 0; k < 8; k++) begin
      if (k <= int'(wr_bytes_q)) lane_mask[8*k +: 8] = 8'hff;
    end
  end
  assign mismatch = |((i_rdata ^ o_req.wdata) & lane_mask);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= ST_IDLE;
      gap_q       <= '0;
      o_req_valid <= 1'b0;
      o_err_cnt   <= '0;
    end else begin
      case (state_q)
        ST_IDLE, ST_DONE: begin
          if (i_start) begin
            o_err_cnt <= '0;
            gap_q     <= '0;
            state_q   <= (i_words == 16'd0) ? ST_DONE : ST_GAP;
          end
        end
        ST_GAP: begin
          if (gap_q == CNT_W'(GAP_CYCLES)) begin
            o_req_valid <= 1'b1;
            state_q     <= ST_REQ;
          end else begin
            gap_q <= gap_q + 1'b1;
          end
        end
        ST_REQ: begin
          if (i_ack) begin
            o_req_valid <= 1'b0;  // low the cycle after ack
            gap_q       <= '0;
            if (o_req.op == REQ_READ) begin
              if (mismatch) o_err_cnt <= o_err_cnt + 16'd1;
              state_q <= last_word ? ST_DONE : ST_GAP;
            end else begin
              state_q <= ST_GAP;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // request payload and walk state
  always_ff @(posedge clk) begin
    if (start_ok) begin
      lfsr_q      <= i_seed;
      words_q     <= i_words;
      wr_bytes_q  <= i_wr_bytes;
      o_req.addr  <= i_base;
      o_req.wdata <= i_seed;
      o_req.bytes <= i_wr_bytes;
      o_req.op    <= REQ_WRITE;
    end else if (state_q == ST_REQ && i_ack) begin
      if (o_req.op == REQ_WRITE) begin
        lfsr_q      <= lfsr_next;
        o_req.op    <= REQ_READ;  // read back the same word
        o_req.bytes <= 3'd7;
      end else begin
        o_last_rdata <= i_rdata;
        words_q      <= words_q - 16'd1;
        o_req.addr   <= o_req.addr + 64'd8;
        o_req.wdata  <= lfsr_q;
        o_req.bytes  <= wr_bytes_q;
        o_req.op     <= REQ_WRITE;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/cache_sys_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// exerciser, cache FSM and array
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module cache_sys_top #(
  parameter int SETS       = 4,
  parameter int GAP_CYCLES = 5
) (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            i_start,
  input  wire [63:0]                     i_seed,
  input  wire [63:0]                     i_base,
  input  wire [15:0]                     i_words,
  input  wire [2:0]                      i_wr_bytes,
  output logic                           o_busy,
  output logic                           o_done,
  output logic [15:0]                    o_err_cnt,
  output logic [cache_pkg::WORD_W-1:0]   o_last_rdata,
  // line port
  output cache_pkg::line_req_t           o_mem,
  output logic                           o_mem_valid,
  input  wire                            i_mem_ready,
  input  wire [cache_pkg::LINE_W-1:0]    i_mem_rdata
);
  import cache_pkg::*;

  localparam int IDX_W = $clog2(SETS);
  localparam int TAG_W = ADDR_W - OFFS_W - IDX_W;

  // core port
  core_req_t         core_req;
  logic              core_req_valid;
  logic              core_ack;
  logic [WORD_W-1:0] core_rdata;

  // array port
  core_req_t         arr_req;
  logic [IDX_W-1:0]  arr_index;
  logic [TAG_W-1:0]  arr_tag;
  logic [TAG_W-1:0]  arr_victim_tag;
  logic              arr_fill;
  logic              arr_write;
  logic              arr_clean;
  logic              arr_hit;
  logic              arr_dirty;
  cache_line_u       arr_fill_line;
  cache_line_u       arr_line;
  logic [WORD_W-1:0] arr_word;

  cache_exerciser #(.GAP_CYCLES(GAP_CYCLES)) u_exerciser (
    .clk          (clk),
    .rst          (rst),
    .i_start      (i_start),
    .i_seed       (i_seed),
    .i_base       (i_base),
    .i_words      (i_words),
    .i_wr_bytes   (i_wr_bytes),
    .o_req        (core_req),
    .o_req_valid  (core_req_valid),
    .i_ack        (core_ack),
    .i_rdata      (core_rdata),
    .o_busy       (o_busy),
    .o_done       (o_done),
    .o_err_cnt    (o_err_cnt),
    .o_last_rdata (o_last_rdata)
  );

  cache_ctrl #(.SETS(SETS)) u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .i_req        (core_req),
    .i_req_valid  (core_req_valid),
    .o_ack        (core_ack),
    .o_rdata      (core_rdata),
    .o_mem        (o_mem),
    .o_mem_valid  (o_mem_valid),
    .i_mem_ready  (i_mem_ready),
    .i_mem_rdata  (i_mem_rdata),
    .o_index      (arr_index),
    .o_tag        (arr_tag),
    .o_fill       (arr_fill),
    .o_fill_line  (arr_fill_line),
    .o_write      (arr_write),
    .o_arr_req    (arr_req),
    .o_clean      (arr_clean),
    .i_hit        (arr_hit),
    .i_dirty      (arr_dirty),
    .i_victim_tag (arr_victim_tag),
    .i_line       (arr_line),
    .i_word       (arr_word)
  );

  cache_array #(.SETS(SETS)) u_array (
    .clk          (clk),
    .rst          (rst),
    .i_index      (arr_index),
    .i_tag        (arr_tag),
    .i_fill       (arr_fill),
    .i_fill_line  (arr_fill_line),
    .i_write      (arr_write),
    .i_req        (arr_req),
    .i_clean      (arr_clean),
    .o_hit        (arr_hit),
    .o_dirty      (arr_dirty),
    .o_victim_tag (arr_victim_tag),
    .o_line       (arr_line),
    .o_word       (arr_word)
  );

endmodule

`default_nettype wire

/* tb/line_mem_model.svh */
// ~~~~~~~~~~~~~~~~~~~~
// line memory model: fill rule, line read/write, transfer counts
// ~~~~~~~~~~~~~~~~~~~~

`ifndef LINE_MEM_MODEL_SVH
`define LINE_MEM_MODEL_SVH

  // every word is its own byte address xor the fill value
  function automatic logic [LINE_W-1:0] fill_line(input logic [63:0] line_addr);
    logic [LINE_W-1:0] line_v;
    for (int k = 0; k < LINE_WORDS; k++) begin
      line_v[64*k +: 64] = (line_addr + 64'(8 * k)) ^ pat.fill;
    end
    return line_v;
  endfunction

  function automatic logic [LINE_W-1:0] read_line(input logic [63:0] line_addr);
    if (mem_lines.exists(line_addr)) return mem_lines[line_addr];
    return fill_line(line_addr);
  endfunction

  task automatic clear_model();
    mem_lines.delete();
    refill_cnt = 0;
    wback_cnt  = 0;
  endtask

  // written-back line must match the bytes the walk left in it
  task automatic write_line(input logic [63:0] line_addr, input logic [LINE_W-1:0] data);
    logic [LINE_W-1:0] exp_v;
    if (!exp_lines.exists(line_addr)) begin
      fail_run($sformatf("%s wrote back line %h that was never written",
                         test_name, line_addr));
    end
    exp_v = exp_lines[line_addr];
    for (int k = 0; k < LINE_WORDS; k++) begin
      check_value($sformatf("%s write-back %h word %0d", test_name, line_addr, k),
                  exp_v[64*k +: 64], data[64*k +: 64]);
    end
    mem_lines[line_addr] = data;
    wback_cnt++;
  endtask

  task automatic serve_line_request();
    int          delay;
    logic [63:0] addr;
    delay = int'($urandom % 6);
    repeat (delay) @(negedge clk);  // ready low, controller holds valid
    addr = mem_req.addr;
    check_value({test_name, " line address alignment"}, 64'd0, 64'(addr[5:0]));
    if (addr < win_lo || addr > win_hi) begin
      fail_run($sformatf("%s line request at %h is outside the test window",
                         test_name, addr));
    end
    if (mem_req.op == REQ_WRITE) begin
      write_line(addr, mem_req.wdata);
    end else begin
      mem_rdata = read_line(addr);
      refill_cnt++;
    end
    mem_ready = 1'b1;  // transfer at the next rising edge
    @(negedge clk);
    mem_ready = 1'b0;
  endtask

`endif

/* tb/tb_cache_sys.sv */
// ~~~~~~~~~~~~~~~~~~~~
// cache system testbench with pattern loop, checks
// and line port responder
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module tb_cache_sys;
  import cache_pkg::*;

  localparam int SETS       = 4;
  localparam int GAP_CYCLES = 5;
  localparam int TIMEOUT    = 20000;  // cycles per wait

  // one row of the patterns file
  typedef struct packed {
    logic [63:0] seed;
    logic [63:0] base;
    logic [15:0] words;
    logic [2:0]  wr_bytes;
    logic [63:0] fill;
    logic [15:0] refills;
    logic [15:0] wbacks;
    logic [63:0] last;
  } pattern_t;

  logic              clk = 1'b0;
  logic              rst = 1'b1;
  logic              start = 1'b0;
  pattern_t          pat = '0;
  logic              busy;
  logic              done;
  logic [15:0]       err_cnt;
  logic [WORD_W-1:0] last_rdata;
  line_req_t         mem_req;
  logic              mem_valid;
  logic              mem_ready = 1'b0;
  logic [LINE_W-1:0] mem_rdata = '0;

  // memory and expected state, used by the model tasks
  logic [LINE_W-1:0] mem_lines [logic [63:0]];  // lines written back
  logic [LINE_W-1:0] exp_lines [logic [63:0]];  // lines as the walk leaves them
  logic [63:0]       win_lo;
  logic [63:0]       win_hi;
  int                refill_cnt = 0;
  int                wback_cnt = 0;
  string             test_name;

  always #2 clk = ~clk;

  cache_sys_top #(.SETS(SETS), .GAP_CYCLES(GAP_CYCLES)) UUT (
    .clk          (clk),
    .rst          (rst),
    .i_start      (start),
    .i_seed       (pat.seed),
    .i_base       (pat.base),
    .i_words      (pat.words),
    .i_wr_bytes   (pat.wr_bytes),
    .o_busy       (busy),
    .o_done       (done),
    .o_err_cnt    (err_cnt),
    .o_last_rdata (last_rdata),
    .o_mem        (mem_req),
    .o_mem_valid  (mem_valid),
    .i_mem_ready  (mem_ready),
    .i_mem_rdata  (mem_rdata)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      fail_run("simulation stopped on a wrong value");
    end
  endtask

  function automatic logic [63:0] lfsr_step(input logic [63:0] x);
    return {x[62:0], x[63] ^ x[62] ^ x[60] ^ x[59]};
  endfunction

  // expected lines, window and last word, straight from the walk rules
  task automatic build_expected(output logic [63:0] last_word, output int lines);
    logic [63:0]       lfsr;
    logic [63:0]       addr;
    logic [63:0]       line_addr;
    logic [LINE_W-1:0] line_v;
    lfsr   = pat.seed;
    lines  = 0;
    addr   = pat.base;
    line_v = '0;
    exp_lines.delete();
    for (int i = 0; i < int'(pat.words); i++) begin
      addr      = pat.base + 64'(8 * i);
      line_addr = {addr[63:6], 6'd0};
      if (exp_lines.exists(line_addr)) begin
        line_v = exp_lines[line_addr];
      end else begin
        line_v = fill_line(line_addr);  // first touch of this line
        lines++;
      end
      for (int k = 0; k <= int'(pat.wr_bytes); k++) begin
        line_v[8 * (int'(addr[5:0]) + k) +: 8] = lfsr[8*k +: 8];
      end
      exp_lines[line_addr] = line_v;
      lfsr = lfsr_step(lfsr);
    end
    win_lo    = {pat.base[63:6], 6'd0};
    win_hi    = {addr[63:6], 6'd0};
    last_word = line_v[8 * int'(addr[5:0]) +: 64];
  endtask

  task automatic run_pattern(input int n);
    logic [63:0] exp_last;
    int          lines;
    int          cycles;
    test_name = $sformatf("pattern %0d", n);
    rst = 1'b1;  // each test starts with an empty cache
    repeat (4) @(negedge clk);
    rst = 1'b0;
    build_expected(exp_last, lines);
    @(negedge clk);
    check_value({test_name, " mem valid after reset"}, 64'd0, 64'(mem_valid));
    check_value({test_name, " busy after reset"}, 64'd0, 64'(busy));
    check_value({test_name, " done after reset"}, 64'd0, 64'(done));
    check_value({test_name, " err count after reset"}, 64'd0, 64'(err_cnt));
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    check_value({test_name, " busy after start"}, 64'd1, 64'(busy));
    cycles = 0;
    while (!done && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!done) begin
      fail_run($sformatf("%s got no done within %0d cycles", test_name, TIMEOUT));
    end
    check_value({test_name, " err count"}, 64'd0, 64'(err_cnt));
    check_value({test_name, " model last word"}, pat.last, exp_last);
    check_value({test_name, " last readback"}, pat.last, last_rdata);
    check_value({test_name, " model line count"}, 64'(pat.refills), 64'(lines));
    check_value({test_name, " refills"}, 64'(pat.refills), 64'(refill_cnt));
    check_value({test_name, " model write-backs"}, 64'(pat.wbacks),
                64'(lines > SETS ? lines - SETS : 0));
    check_value({test_name, " write-backs"}, 64'(pat.wbacks), 64'(wback_cnt));
  endtask

  // line port responder, random ready delay
  initial begin
    void'($urandom(58));
    forever begin
      @(negedge clk);
      if (rst) begin
        clear_model();
      end else if (mem_valid) begin
        serve_line_request();
      end
    end
  end

  initial begin
    int          fd;
    int          rc;
    int          n;
    string       line_s;
    logic [63:0] col [8];
    n  = 0;
    fd = $fopen("tb/cache_patterns.txt", "r");
    if (fd == 0) begin
      fail_run("could not open tb/cache_patterns.txt");
    end
    while (!$feof(fd)) begin
      rc = $fgets(line_s, fd);
      if (rc > 1 && line_s.getc(0) != "#") begin
        rc = $sscanf(line_s, "%h %h %h %h %h %h %h %h",
                     col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7]);
        if (rc != 8) begin
          fail_run({"malformed line in the patterns file: ", line_s});
        end
        @(negedge clk);
        pat.seed     = col[0];
        pat.base     = col[1];
        pat.words    = col[2][15:0];
        pat.wr_bytes = col[3][2:0];
        pat.fill     = col[4];
        pat.refills  = col[5][15:0];
        pat.wbacks   = col[6][15:0];
        pat.last     = col[7];
        run_pattern(n);
        n++;
      end
    end
    $fclose(fd);
    if (n == 0) begin
      fail_run("the patterns file holds no tests");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

  `include "line_mem_model.svh"

endmodule

`default_nettype wire

/* tb/cache_patterns.txt */
# seed base words wr_bytes fill refills wbacks last_rdata, all hex
# wr_bytes is the byte count minus one, fill is xored into each word address
0000000000000001 0000000000001000 0030 7 5555aaaa5555aaaa 6 2 0000800000000000
000a5a5a5a5a5a5a 0000000000002038 0008 0 1111111111111111 2 0 1111111111113100
0800000000000001 0000000000003000 0002 3 ffff0000ffff0000 1 0 ffff000000000003
000000000000beef 0000000000008030 0022 5 a5a5a5a5a5a5a5a5 5 1 a5a57dde00000000

/* tb.f */
+incdir+tb
hdl/cache_pkg.sv
hdl/cache_array.sv
hdl/cache_ctrl.sv
hdl/cache_exerciser.sv
hdl/cache_sys_top.sv
tb/tb_cache_sys.sv

/* run.sh */
#!/bin/sh
# build the cache system testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --top-module tb_cache_sys -f tb.f || exit 1
out=$(./obj_dir/Vtb_cache_sys)
echo "$out"
echo "$out" | grep -qxF '>>> PASS' && exit 0 || exit 1
